/* design/sd_proto_pkg.sv */
package sd_proto_pkg;

	//////////////////////////////
	// Command line framing
	//////////////////////////////

	// Every command and R1 response frame
	localparam int FRAME_BITS = 48;

	// CRC7 length and generator x^7 + x^3 + 1
	localparam int CRC_BITS = 7;
	localparam logic [CRC_BITS-1:0] CRC_POLY = 7'h09;

	// Command or response index
	typedef logic [5:0] cmd_index_t;

	// Command argument or card status
	typedef logic [31:0] cmd_arg_t;

	// CRC remainder
	typedef logic [CRC_BITS-1:0] crc7_t;

	// Bit counter, must reach 48
	typedef logic [5:0] frame_count_t;

	// Advance the remainder by one line bit
	// Remainder starts at zero, fed MSB first
	function automatic crc7_t crc7_step(input crc7_t crc, input logic bit_in);
		crc7_t shifted;
		shifted = {crc[CRC_BITS-2:0], 1'b0};
		if (crc[CRC_BITS-1] ^ bit_in)
			return shifted ^ CRC_POLY;
		else
			return shifted;
	endfunction

endpackage

/* design/sd_ctrl_pkg.sv */
package sd_ctrl_pkg;

	//////////////////////////////
	// Host side encodings
	//////////////////////////////

	// Response expected after the command
	typedef enum logic {
		RSP_NONE = 1'b0,
		RSP_R1   = 1'b1
	} resp_type_t;

	// Result code returned with every command
	// Zero is the timeout code
	typedef enum logic [1:0] {
		ERR_TIMEOUT = 2'd0,
		ERR_OKAY    = 2'd1,
		ERR_BADCRC  = 2'd2,
		ERR_FRAME   = 2'd3
	} err_code_t;

endpackage

/* design/sd_cmd_fsm.sv */
`timescale 1ns/10ps

module sd_cmd_fsm (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_cmd_valid,
	input  sd_ctrl_pkg::resp_type_t i_cmd_rsp_type,
	input  logic                    i_tx_done,
	input  logic                    i_rx_done,
	input  sd_ctrl_pkg::err_code_t  i_rx_err,
	input  logic                    i_timeout,
	input  logic                    i_rsp_ready,
	output logic                    o_cmd_ready,
	output logic                    o_tx_start,
	output logic                    o_rx_enable,
	output logic                    o_timer_run,
	output logic                    o_rsp_valid,
	output sd_ctrl_pkg::err_code_t  o_rsp_err
);
	import sd_ctrl_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		SEND,
		WAIT_RESP,
		REPORT
	} state_t;

	state_t     state;
	state_t     state_next;
	resp_type_t rsp_type;

	//////////////////////////////
	// Sequencing
	//////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
				if (i_cmd_valid && o_cmd_ready)
					state_next = SEND;
			// Last bit decides between reply and direct report
			SEND:
				if (i_tx_done)
					state_next = (rsp_type == RSP_R1) ? WAIT_RESP : REPORT;
			WAIT_RESP:
				if (i_rx_done || i_timeout)
					state_next = REPORT;
			// Hold the result until the host takes it
			REPORT:
				if (i_rsp_ready)
					state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state       <= IDLE;
			o_cmd_ready <= 1'b0;
			rsp_type    <= RSP_NONE;
		end
		else
		begin
			state <= state_next;
			// Registered so it stays low through reset
			o_cmd_ready <= (state_next == IDLE);
			if (o_tx_start)
				rsp_type <= i_cmd_rsp_type;
		end
	end

	// Result code, captured where the outcome is known
	always_ff @(posedge i_clk)
	begin
		if (state == SEND && i_tx_done)
			o_rsp_err <= ERR_OKAY;
		else if (state == WAIT_RESP && i_rx_done)
			o_rsp_err <= i_rx_err;
		else if (state == WAIT_RESP && i_timeout)
			o_rsp_err <= ERR_TIMEOUT;
	end

	assign o_tx_start  = i_cmd_valid && o_cmd_ready;
	assign o_timer_run = (state == WAIT_RESP);
	// Receiver stays enabled while an R1 result is on offer
	// so its captured index and status stay visible
	assign o_rx_enable = (state == WAIT_RESP) ||
		(state == REPORT && rsp_type == RSP_R1);
	assign o_rsp_valid = (state == REPORT);

endmodule

/* design/sd_cmd_timer.sv */
`timescale 1ns/10ps

module sd_cmd_timer #(
	parameter int TIMEOUT_CYCLES = 64
) (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_run,
	input  logic i_cmd_strb,
	output logic o_timeout
);

	localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
	// Zero is reached on the last idle cycle
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TIMEOUT_CYCLES - 1);

	logic [CNT_W-1:0] count;

	// Reload while stopped or on any strobe
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_run || i_cmd_strb)
			count <= RELOAD;
		else if (count != '0)
			count <= count - 1'b1;
	end

	// One pulse, the FSM leaves the wait on it
	assign o_timeout = i_run && !i_cmd_strb && (count == '0);

endmodule

/* design/sd_cmd_tx.sv */
`timescale 1ns/10ps

module sd_cmd_tx (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_start,
	input  sd_proto_pkg::cmd_index_t i_index,
	input  sd_proto_pkg::cmd_arg_t   i_arg,
	output logic                     o_tx_done,
	output logic                     o_cmd_en,
	output logic                     o_cmd_bit
);
	import sd_proto_pkg::*;

	// Start, transmission, index and argument
	localparam int HEAD_BITS = FRAME_BITS - CRC_BITS - 1;

	logic [FRAME_BITS-1:0] shreg;
	logic [HEAD_BITS-1:0]  head;
	crc7_t                 crc;
	frame_count_t          count;

	//////////////////////////////
	// Frame build
	//////////////////////////////

	always_comb
	begin
		head = {2'b01, i_index, i_arg};
		crc  = '0;
		// MSB first, same order as the line
		for (int i = HEAD_BITS - 1; i >= 0; i--)
			crc = crc7_step(crc, head[i]);
	end

	//////////////////////////////
	// Serializer
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			count <= '0;
			shreg <= '1;
		end
		else if (i_start)
		begin
			count <= frame_count_t'(FRAME_BITS);
			shreg <= {head, crc, 1'b1};
		end
		else if (count != '0)
		begin
			count <= count - 1'b1;
			// Ones behind the frame, line idles high
			shreg <= {shreg[FRAME_BITS-2:0], 1'b1};
		end
	end

	assign o_cmd_en  = (count != '0);
	assign o_cmd_bit = shreg[FRAME_BITS-1];
	assign o_tx_done = (count == frame_count_t'(1));

endmodule

/* design/sd_cmd_rx.sv */
`timescale 1ns/10ps

module sd_cmd_rx (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_enable,
	input  logic                     i_cmd_strb,
	input  logic                     i_cmd_bit,
	output logic                     o_rx_done,
	output sd_ctrl_pkg::err_code_t   o_rx_err,
	output sd_proto_pkg::cmd_index_t o_index,
	output sd_proto_pkg::cmd_arg_t   o_arg
);
	import sd_proto_pkg::*;
	import sd_ctrl_pkg::*;

	// Bits covered by the CRC
	localparam frame_count_t CRC_END  = frame_count_t'(FRAME_BITS - CRC_BITS - 1);
	localparam frame_count_t LAST_BIT = frame_count_t'(FRAME_BITS - 1);
	localparam frame_count_t ALL_BITS = frame_count_t'(FRAME_BITS);

	logic [FRAME_BITS-1:0] shreg;
	frame_count_t          count;
	crc7_t                 crc;
	logic                  frame_err;
	logic                  take;
	logic                  crc_bad;
	logic                  end_bad;

	// Strobed bit while enabled, nothing past bit 48
	assign take = i_enable && i_cmd_strb && (count < ALL_BITS);

	//////////////////////////////
	// Capture
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (take)
			shreg <= {shreg[FRAME_BITS-2:0], i_cmd_bit};
	end

	// Counter, CRC and start check restart on each enable
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_enable)
		begin
			count     <= '0;
			crc       <= '0;
			frame_err <= 1'b0;
		end
		else if (take)
		begin
			count <= count + 1'b1;
			if (count < CRC_END)
				crc <= crc7_step(crc, i_cmd_bit);
			// Both leading bits must be zero
			if (count < frame_count_t'(2) && i_cmd_bit)
				frame_err <= 1'b1;
		end
	end

	//////////////////////////////
	// Checks on the last bit
	//////////////////////////////

	// Received CRC sits in the low bits until the end bit shifts in
	assign crc_bad = (crc != shreg[CRC_BITS-1:0]);
	assign end_bad = !i_cmd_bit;

	always_comb
	begin
		if (crc_bad)
			o_rx_err = ERR_BADCRC;
		else if (frame_err || end_bad)
			o_rx_err = ERR_FRAME;
		else
			o_rx_err = ERR_OKAY;
	end

	assign o_rx_done = take && (count == LAST_BIT);

	// Field positions after all 48 shifts
	// Zero while disabled
	assign o_index = i_enable ? shreg[45:40] : '0;
	assign o_arg   = i_enable ? shreg[39:8] : '0;

endmodule

/* design/sd_cmd_top.sv */
`timescale 1ns/10ps

module sd_cmd_top #(
	parameter int TIMEOUT_CYCLES = 64
) (
	input  logic                     i_clk,
	input  logic                     i_reset,
	// Host command
	input  logic                     i_cmd_valid,
	output logic                     o_cmd_ready,
	input  sd_proto_pkg::cmd_index_t i_cmd_index,
	input  sd_proto_pkg::cmd_arg_t   i_cmd_arg,
	input  sd_ctrl_pkg::resp_type_t  i_cmd_rsp_type,
	// Result
	output logic                     o_rsp_valid,
	input  logic                     i_rsp_ready,
	output sd_ctrl_pkg::err_code_t   o_rsp_err,
	output sd_proto_pkg::cmd_index_t o_rsp_index,
	output sd_proto_pkg::cmd_arg_t   o_rsp_arg,
	// Card line
	output logic                     o_cmd_en,
	output logic                     o_cmd_bit,
	input  logic                     i_cmd_strb,
	input  logic                     i_cmd_bit
);
	import sd_ctrl_pkg::*;

	logic      tx_start;
	logic      tx_done;
	logic      rx_enable;
	logic      timer_run;
	logic      rx_done;
	err_code_t rx_err;
	logic      timeout;

	sd_cmd_fsm sd_cmd_fsm_inst (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_cmd_valid    (i_cmd_valid),
		.i_cmd_rsp_type (i_cmd_rsp_type),
		.i_tx_done      (tx_done),
		.i_rx_done      (rx_done),
		.i_rx_err       (rx_err),
		.i_timeout      (timeout),
		.i_rsp_ready    (i_rsp_ready),
		.o_cmd_ready    (o_cmd_ready),
		.o_tx_start     (tx_start),
		.o_rx_enable    (rx_enable),
		.o_timer_run    (timer_run),
		.o_rsp_valid    (o_rsp_valid),
		.o_rsp_err      (o_rsp_err)
	);

	sd_cmd_timer #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) sd_cmd_timer_inst (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_run      (timer_run),
		.i_cmd_strb (i_cmd_strb),
		.o_timeout  (timeout)
	);

	sd_cmd_tx sd_cmd_tx_inst (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_start   (tx_start),
		.i_index   (i_cmd_index),
		.i_arg     (i_cmd_arg),
		.o_tx_done (tx_done),
		.o_cmd_en  (o_cmd_en),
		.o_cmd_bit (o_cmd_bit)
	);

	// Index and status read zero unless an R1 result is held
	sd_cmd_rx sd_cmd_rx_inst (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_enable   (rx_enable),
		.i_cmd_strb (i_cmd_strb),
		.i_cmd_bit  (i_cmd_bit),
		.o_rx_done  (rx_done),
		.o_rx_err   (rx_err),
		.o_index    (o_rsp_index),
		.o_arg      (o_rsp_arg)
	);

endmodule

/* tests/sd_cmd_chk.sv */
`timescale 1ns/10ps

module sd_cmd_chk (
	input logic                     i_clk,
	input logic                     i_reset,
	input logic                     o_cmd_en,
	input logic                     o_cmd_ready,
	input logic                     o_rsp_valid,
	input logic                     i_rsp_ready,
	input sd_ctrl_pkg::err_code_t   o_rsp_err,
	input sd_proto_pkg::cmd_index_t o_rsp_index,
	input sd_proto_pkg::cmd_arg_t   o_rsp_arg
);

	// No acceptance while a frame is on the line
	en_vs_ready: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_cmd_en && o_cmd_ready))
		else $error("o_cmd_en and o_cmd_ready high together");

	// Result only after the last bit
	valid_vs_en: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_rsp_valid && o_cmd_en))
		else $error("o_rsp_valid and o_cmd_en high together");

	// Stalled result holds
	rsp_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp_err) &&
		$stable(o_rsp_index) && $stable(o_rsp_arg)))
		else $error("Result changed before hand-off");

	// Quiet outputs right after a reset cycle
	reset_quiet: assert property (@(posedge i_clk)
		$past(i_reset) |-> (!o_cmd_en && !o_rsp_valid && !o_cmd_ready))
		else $error("Outputs active after reset");

endmodule

bind sd_cmd_top sd_cmd_chk sd_cmd_chk_inst (
	.i_clk       (i_clk),
	.i_reset     (i_reset),
	.o_cmd_en    (o_cmd_en),
	.o_cmd_ready (o_cmd_ready),
	.o_rsp_valid (o_rsp_valid),
	.i_rsp_ready (i_rsp_ready),
	.o_rsp_err   (o_rsp_err),
	.o_rsp_index (o_rsp_index),
	.o_rsp_arg   (o_rsp_arg)
);

/* tests/tb_sd_cmd.sv */
`timescale 1ns/10ps

module tb_sd_cmd;
	import sd_proto_pkg::*;
	import sd_ctrl_pkg::*;

	localparam int NUM_CMDS       = 80;
	localparam int TIMEOUT_CYCLES = 64;
	// Transmit, reply delay, slow reply, timeout and stalls per command
	localparam int MAX_CYCLES     = NUM_CMDS * (48 + 20 + 48 * 4 + 64 + 20);

	logic       i_clk;
	logic       i_reset;
	logic       i_cmd_valid;
	logic       o_cmd_ready;
	cmd_index_t i_cmd_index;
	cmd_arg_t   i_cmd_arg;
	resp_type_t i_cmd_rsp_type;
	logic       o_rsp_valid;
	logic       i_rsp_ready;
	err_code_t  o_rsp_err;
	cmd_index_t o_rsp_index;
	cmd_arg_t   o_rsp_arg;
	logic       o_cmd_en;
	logic       o_cmd_bit;
	logic       i_cmd_strb;
	logic       i_cmd_bit;

	integer                seed = 32'hfd30a007;
	int                    cycles = 0;
	int                    kind;
	logic [FRAME_BITS-1:0] frame;
	logic [39:0]           head;
	crc7_t                 crc;
	err_code_t             exp_err;
	cmd_index_t            exp_index;
	cmd_arg_t              exp_arg;

	sd_cmd_top #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) sd_cmd_top_inst (.*);

	always #20 i_clk = ~i_clk;

	// Run limit
	always @(posedge i_clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			stop_run("Run did not finish within the cycle limit");
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "Stopped at first error");
	endtask

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %0b expected %0b", $time, name, got, exp);
			stop_run("Line or handshake bit mismatch");
		end
	endtask

	task automatic check_err(input err_code_t got, input err_code_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: o_rsp_err got %s expected %s",
				$time, got.name(), exp.name());
			stop_run("Wrong result code");
		end
	endtask

	task automatic check_index(input cmd_index_t got, input cmd_index_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: o_rsp_index got %0h expected %0h", $time, got, exp);
			stop_run("Wrong response index");
		end
	endtask

	task automatic check_arg(input cmd_arg_t got, input cmd_arg_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: o_rsp_arg got %0h expected %0h", $time, got, exp);
			stop_run("Wrong response status");
		end
	endtask

	// Reference CRC7 with x^7 + x^3 + 1 over 40 bits MSB first
	function automatic crc7_t calc_crc7(input logic [39:0] bits);
		crc7_t r;
		logic  fb;
		r = '0;
		for (int i = 39; i >= 0; i--)
		begin
			fb = r[6] ^ bits[i];
			r  = {r[5:0], 1'b0};
			if (fb)
				r = r ^ 7'h09;
		end
		return r;
	endfunction

	//////////////////////////////
	// Host and card sequences
	//////////////////////////////

	// Offer one command and check all 48 line bits and the idle line after them
	task automatic send_command;
		logic [FRAME_BITS-1:0] exp_frame;
		i_cmd_valid = 1'b1;
		exp_frame   = {2'b01, i_cmd_index, i_cmd_arg, calc_crc7({2'b01, i_cmd_index, i_cmd_arg}),
			1'b1};
		@(negedge i_clk);
		while (!o_cmd_ready)
			@(negedge i_clk);
		@(posedge i_clk);
		#2;
		i_cmd_valid = 1'b0;
		for (int i = FRAME_BITS - 1; i >= 0; i--)
		begin
			@(negedge i_clk);
			check_bit("o_cmd_en", o_cmd_en, 1'b1);
			check_bit("o_cmd_bit", o_cmd_bit, exp_frame[i]);
		end
		// Frame ends after exactly 48 cycles
		@(negedge i_clk);
		check_bit("o_cmd_en", o_cmd_en, 1'b0);
		check_bit("o_cmd_bit", o_cmd_bit, 1'b1);
	endtask

	// Card reply with random delay and gaps
	task automatic card_reply(input logic [FRAME_BITS-1:0] bits);
		repeat (1 + {$random(seed)} % 20)
		begin
			@(posedge i_clk);
			#2;
		end
		for (int i = FRAME_BITS - 1; i >= 0; i--)
		begin
			repeat ({$random(seed)} % 4)
			begin
				@(posedge i_clk);
				#2;
				i_cmd_strb = 1'b0;
			end
			@(posedge i_clk);
			#2;
			i_cmd_strb = 1'b1;
			i_cmd_bit  = bits[i];
		end
		@(posedge i_clk);
		#2;
		i_cmd_strb = 1'b0;
		i_cmd_bit  = 1'b1;
		@(negedge i_clk);
		check_bit("o_rsp_valid", o_rsp_valid, 1'b1);
	endtask

	// Hold the result under random stalls until it is taken
	task automatic take_result(input logic check_fields);
		logic taken;
		taken = 1'b0;
		while (!taken)
		begin
			check_bit("o_rsp_valid", o_rsp_valid, 1'b1);
			check_bit("o_cmd_ready", o_cmd_ready, 1'b0);
			check_err(o_rsp_err, exp_err);
			if (check_fields)
			begin
				check_index(o_rsp_index, exp_index);
				check_arg(o_rsp_arg, exp_arg);
			end
			taken = i_rsp_ready;
			@(posedge i_clk);
			#2;
			i_rsp_ready = 1'($random(seed));
			@(negedge i_clk);
		end
		// Delivered once only
		check_bit("o_rsp_valid", o_rsp_valid, 1'b0);
		// Next command starts just after a rising edge
		@(posedge i_clk);
		#2;
	endtask

	initial
	begin
		i_clk          = 1'b0;
		i_reset        = 1'b1;
		i_cmd_valid    = 1'b0;
		i_cmd_index    = '0;
		i_cmd_arg      = '0;
		i_cmd_rsp_type = RSP_NONE;
		i_rsp_ready    = 1'b0;
		i_cmd_strb     = 1'b0;
		i_cmd_bit      = 1'b1;
		repeat (5) @(posedge i_clk);
		#2;
		i_reset = 1'b0;
		for (int n = 0; n < NUM_CMDS; n++)
		begin
			i_cmd_index    = cmd_index_t'($random(seed));
			i_cmd_arg      = $random(seed);
			i_cmd_rsp_type = resp_type_t'({$random(seed)} % 2);
			i_rsp_ready    = 1'($random(seed));
			send_command();
			if (i_cmd_rsp_type == RSP_NONE)
			begin
				exp_err   = ERR_OKAY;
				exp_index = '0;
				exp_arg   = '0;
				check_bit("o_rsp_valid", o_rsp_valid, 1'b1);
				take_result(1'b1);
			end
			else
			begin
				// 0 good, 1 CRC, 2 start, 3 end, 4 CRC and start, 5 silent
				kind      = {$random(seed)} % 6;
				exp_index = cmd_index_t'($random(seed));
				exp_arg   = $random(seed);
				head      = {2'b00, exp_index, exp_arg};
				if (kind == 2 || kind == 4)
					head[38 + {$random(seed)} % 2] = 1'b1;
				crc = calc_crc7(head);
				if (kind == 1 || kind == 4)
					crc[{$random(seed)} % 7] ^= 1'b1;
				frame = {head, crc, (kind != 3)};
				case (kind)
					0:       exp_err = ERR_OKAY;
					1, 4:    exp_err = ERR_BADCRC;
					2, 3:    exp_err = ERR_FRAME;
					default: exp_err = ERR_TIMEOUT;
				endcase
				if (kind == 5)
				begin
					// No result until the idle timer runs out
					repeat (TIMEOUT_CYCLES)
					begin
						check_bit("o_rsp_valid", o_rsp_valid, 1'b0);
						@(negedge i_clk);
					end
				end
				else
					card_reply(frame);
				take_result(kind != 5);
			end
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

/* filelist.f */
design/sd_proto_pkg.sv
design/sd_ctrl_pkg.sv
design/sd_cmd_fsm.sv
design/sd_cmd_timer.sv
design/sd_cmd_tx.sv
design/sd_cmd_rx.sv
design/sd_cmd_top.sv
tests/sd_cmd_chk.sv
tests/tb_sd_cmd.sv

/* Makefile */
TOP   = tb_sd_cmd
BUILD = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD) -f filelist.f
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
